//--- tb.f
+incdir+include
design/arch_pkg.sv
design/pipe_pkg.sv
design/ew_latch.sv
design/store_credit_counter.sv
design/wb_sequencer.sv
design/gpr_file.sv
design/seg_file.sv
design/wb_stage_top.sv
testbench/tb_clock.sv
testbench/wb_stage_tb.sv

//--- testbench/wb_stage_tb.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_stage_tb;

    import arch_pkg::*;
    import pipe_pkg::*;

    localparam int max_rows   = 16;
    localparam int max_cycles = 1000;
    localparam int hold_start = 14;  // memory keeps its credits in this window
    localparam int hold_end   = 50;
    localparam int to_gpr     = 1;
    localparam int to_seg     = 2;
    localparam int to_mem     = 3;
    localparam res_slot_t no_slot = '0;

    logic       clk;
    logic       rst_n;
    logic       ew_valid;
    ew_entry_t  ew_entry;
    logic       ew_credit;
    logic       store_valid;
    store_req_t store_req;
    logic       store_credit;
    logic       commit_valid;
    commit_t    commit;
    gpr_idx_t   gpr_rd_idx;
    data_t      gpr_rd_data;
    seg_idx_t   seg_rd_idx;
    seg_val_t   seg_rd_data;

    ew_entry_t   rows [max_rows];
    commit_t     exp_commit [max_rows];
    int          exp_gap [max_rows];     // cycles after the previous commit
    bit          row_stores [max_rows];
    int          push_cycle [max_rows];
    int          n_rows;
    data_t       shadow_gpr [`WB_NUM_GPR];
    seg_val_t    shadow_seg [`WB_NUM_SEG];
    store_req_t  exp_stores [$];
    int          credit_due [$];         // cycle at which memory frees a slot
    int unsigned lcg_state;

    tb_clock tb_clock_i (.clk(clk));

    wb_stage_top wb_stage_top_i (.*);

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic res_slot_t make_slot(int kind, addr_t dest, data_t value);
        res_slot_t s;
        s        = '0;
        s.wb     = (kind != 0);
        s.is_reg = (kind == to_gpr);
        s.is_seg = (kind == to_seg);
        s.is_mem = (kind == to_mem);
        s.dest   = dest;
        s.value  = value;
        return s;
    endfunction

    task automatic fail_value(string name, logic [127:0] got, logic [127:0] exp);
        $display("FAIL at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic fail_text(string what);
        $display("error at %0d ns: %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    task automatic add_row(addr_t eip, eflags_t fl, logic ie, exc_type_t ie_type,
                           opsize_t size, res_slot_t s0, res_slot_t s1,
                           res_slot_t s2, res_slot_t s3);
        ew_entry_t e;
        int        k;
        e         = '0;
        e.eip     = eip;
        e.eflags  = fl;
        e.ie      = ie;
        e.ie_type = ie_type;
        e.ressize = size;
        e.slots   = {s3, s2, s1, s0};
        k = int'(s0.wb) + int'(s1.wb) + int'(s2.wb) + int'(s3.wb);
        rows[n_rows]       = e;
        exp_commit[n_rows] = '{eip: eip, eflags: fl, ie: ie, ie_type: ie_type};
        exp_gap[n_rows]    = ie ? 1 : k + 1;  // exception retires at once
        row_stores[n_rows] = !ie && (s0.is_mem || s1.is_mem || s2.is_mem || s3.is_mem);
        n_rows++;
    endtask

    // reference model applies slots in order and skips exceptions
    task automatic apply_row(ew_entry_t e);
        res_slot_t  s;
        store_req_t r;
        data_t      old;
        int         idx;
        if (!e.ie) begin
            for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
                s   = e.slots[i];
                idx = s.dest[2:0];
                if (s.wb && s.is_reg) begin
                    old = shadow_gpr[idx];
                    case (e.ressize)
                        `SIZE_BYTE: shadow_gpr[idx] = {old[31:8], s.value[7:0]};
                        `SIZE_WORD: shadow_gpr[idx] = {old[31:16], s.value[15:0]};
                        default:    shadow_gpr[idx] = s.value;
                    endcase
                end else if (s.wb && s.is_seg) begin
                    if (idx < `WB_NUM_SEG) begin
                        shadow_seg[idx] = s.value[15:0];
                    end
                end else if (s.wb && s.is_mem) begin
                    r = '{addr: s.dest, data: s.value, size: e.ressize};
                    exp_stores.push_back(r);
                end
            end
        end
    endtask

    task automatic build_table();
        add_row(32'h1000, 18'h00002, 0, 0, `SIZE_DWORD, make_slot(to_gpr, 0, 32'h1122_3344),
                make_slot(to_gpr, 1, 32'haabb_ccdd), no_slot, no_slot);
        add_row(32'h1004, 18'h00046, 0, 0, `SIZE_BYTE, make_slot(to_gpr, 0, 32'hffff_ff5a),
                no_slot, no_slot, no_slot);
        add_row(32'h1006, 18'h00202, 0, 0, `SIZE_WORD, make_slot(to_gpr, 1, 32'h1234_9876),
                no_slot, no_slot, no_slot);
        add_row(32'h100a, 18'h00003, 0, 0, `SIZE_DWORD, make_slot(to_seg, 2, 32'hbeef_0023),
                make_slot(to_gpr, 2, 32'h0bad_f00d), no_slot, no_slot);
        add_row(32'h1010, 18'h00097, 0, 0, `SIZE_DWORD, make_slot(to_mem, 32'h2000, 32'hdead_beef),
                make_slot(to_gpr, 3, 32'h3333_3333), no_slot, no_slot);
        // faulting entry drops all of its results
        add_row(32'h1014, 18'h00202, 1, 4'd6, `SIZE_DWORD, make_slot(to_gpr, 7, 32'h7777_7777),
                make_slot(to_seg, 5, 32'h5555), make_slot(to_mem, 32'h3000, 32'h1234_5678),
                no_slot);
        add_row(32'h2000, 18'h00002, 0, 0, `SIZE_DWORD, no_slot, no_slot, no_slot, no_slot);
        add_row(32'h2004, 18'h00802, 0, 0, `SIZE_DWORD, make_slot(to_mem, 32'h2100, 32'hcafe_0000),
                make_slot(to_mem, 32'h2104, 32'hcafe_0001),
                make_slot(to_mem, 32'h2108, 32'hcafe_0002),
                make_slot(to_mem, 32'h210c, 32'hcafe_0003));
        add_row(32'h2008, 18'h00006, 0, 0, `SIZE_BYTE, make_slot(to_mem, 32'h2200, 32'h0000_00a5),
                make_slot(to_gpr, 4, 32'h4444_4444), make_slot(to_mem, 32'h2201, 32'h5a),
                make_slot(to_mem, 32'h2202, 32'h3c));
        add_row(32'h200c, 18'h00046, 0, 0, `SIZE_WORD, no_slot,
                make_slot(to_gpr, 5, 32'h5555_1234), no_slot, make_slot(to_seg, 4, 32'h4444));
        add_row(32'h2010, 18'h10202, 1, 4'd13, `SIZE_DWORD, make_slot(to_gpr, 0, 32'hffff_ffff),
                make_slot(to_seg, 2, 32'hffff), no_slot, no_slot);
        add_row(32'h2014, 18'h00002, 0, 0, `SIZE_BYTE, make_slot(to_gpr, 4, 32'h0000_00aa),
                make_slot(to_gpr, 4, 32'h0000_00bb), no_slot, no_slot);
        add_row(32'h2018, 18'h00083, 0, 0, `SIZE_WORD, make_slot(to_mem, 32'h2300, 32'h1111_beef),
                make_slot(to_mem, 32'h2302, 32'h2222_cafe), no_slot, no_slot);
        add_row(32'h201c, 18'h00202, 0, 0, `SIZE_DWORD, make_slot(to_gpr, 6, 32'h6666_6666),
                make_slot(to_seg, 0, 32'hf000), make_slot(to_seg, 1, 32'h0008),
                make_slot(to_gpr, 2, 32'h1234_5678));
    endtask

    initial begin
        int         cycle;
        int         committed;
        int         next_row;
        int         credits;
        int         prev_commit;
        int         outstanding;
        logic       saw_commit;
        logic       starved;
        store_req_t want;
        lcg_state    = 33;
        n_rows       = 0;
        rst_n        = 1'b0;
        ew_valid     = 1'b0;
        ew_entry     = '0;
        store_credit = 1'b0;
        gpr_rd_idx   = '0;
        seg_rd_idx   = '0;
        for (int i = 0; i < `WB_NUM_GPR; i++) begin
            shadow_gpr[i] = '0;
        end
        for (int i = 0; i < `WB_NUM_SEG; i++) begin
            shadow_seg[i] = '0;
        end
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n       = 1'b1;
        cycle       = 0;
        committed   = 0;
        next_row    = 0;
        credits     = `EW_DEPTH;
        prev_commit = -1;
        outstanding = 0;
        starved     = 1'b0;

        // sample outputs before driving the next inputs
        while (committed < n_rows) begin
            assert (cycle < max_cycles) else fail_text("timed out waiting for commits");
            saw_commit = commit_valid;
            assert (ew_credit == commit_valid) else
                fail_value("ew_credit", ew_credit, commit_valid);
            if (commit_valid) begin
                assert (committed < next_row) else fail_text("commit with no entry sent");
                assert (commit == exp_commit[committed]) else
                    fail_value("commit", commit, exp_commit[committed]);
                // only entries that were already queued have a fixed latency
                if (committed > 0 && push_cycle[committed] <= prev_commit) begin
                    if (row_stores[committed] && starved) begin
                        assert (cycle - prev_commit >= exp_gap[committed]) else
                            fail_value("commit gap", cycle - prev_commit, exp_gap[committed]);
                    end else begin
                        assert (cycle - prev_commit == exp_gap[committed]) else
                            fail_value("commit gap", cycle - prev_commit, exp_gap[committed]);
                    end
                end
                prev_commit = cycle;
                committed++;
                starved     = 1'b0;
            end else if (outstanding == `STORE_CREDITS) begin
                starved = 1'b1;  // no store credit left this cycle
            end
            if (store_valid) begin
                assert (exp_stores.size() > 0) else fail_text("store issued with none expected");
                want = exp_stores.pop_front();
                assert (store_req == want) else fail_value("store_req", store_req, want);
                outstanding++;
                assert (outstanding <= `STORE_CREDITS) else
                    fail_value("stores outstanding", outstanding, `STORE_CREDITS);
                credit_due.push_back(cycle + int'((lcg_next() >> 16) % 6));
            end

            store_credit = 1'b0;
            if (credit_due.size() > 0 && !(cycle >= hold_start && cycle < hold_end)) begin
                if (credit_due[0] <= cycle) begin
                    void'(credit_due.pop_front());
                    store_credit = 1'b1;
                    outstanding--;
                end
            end
            if (next_row < n_rows && credits > 0) begin
                ew_valid             = 1'b1;
                ew_entry             = rows[next_row];
                push_cycle[next_row] = cycle;
                apply_row(rows[next_row]);
                next_row++;
                credits--;
            end else begin
                ew_valid = 1'b0;
                ew_entry = '0;
            end
            if (saw_commit) begin
                credits++;  // usable from the next cycle on
            end
            @(negedge clk);
            cycle++;
        end

        ew_valid     = 1'b0;
        store_credit = 1'b0;
        assert (exp_stores.size() == 0) else fail_text("some expected stores never issued");

        for (int i = 0; i < `WB_NUM_GPR; i++) begin
            gpr_rd_idx = gpr_idx_t'(i);
            seg_rd_idx = seg_idx_t'(i);
            @(negedge clk);
            assert (gpr_rd_data == shadow_gpr[i]) else
                fail_value($sformatf("gpr_rd_data[%0d]", i), gpr_rd_data, shadow_gpr[i]);
            if (i < `WB_NUM_SEG) begin
                assert (seg_rd_data == shadow_seg[i]) else
                    fail_value($sformatf("seg_rd_data[%0d]", i), seg_rd_data, shadow_seg[i]);
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

endmodule

//--- design/wb_stage_top.sv
`timescale 1ns/1ps

module wb_stage_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ew_valid,
    input  pipe_pkg::ew_entry_t  ew_entry,
    output logic                 ew_credit,
    output logic                 store_valid,
    output pipe_pkg::store_req_t store_req,
    input  logic                 store_credit,
    output logic                 commit_valid,
    output pipe_pkg::commit_t    commit,
    input  arch_pkg::gpr_idx_t   gpr_rd_idx,
    output arch_pkg::data_t      gpr_rd_data,
    input  arch_pkg::seg_idx_t   seg_rd_idx,
    output arch_pkg::seg_val_t   seg_rd_data
);

    import arch_pkg::*;
    import pipe_pkg::*;

    logic      head_valid;
    ew_entry_t head;
    logic      have_credit;
    logic      gpr_we;
    gpr_idx_t  gpr_wr_idx;
    data_t     gpr_wr_data;
    opsize_t   gpr_wr_size;
    logic      seg_we;
    seg_idx_t  seg_wr_idx;
    data_t     seg_wr_data;

    ew_latch ew_latch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (ew_valid),
        .push_entry (ew_entry),
        .pop        (ew_credit),  // the retire pop is the returned credit
        .head_valid (head_valid),
        .head       (head)
    );

    wb_sequencer wb_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid   (head_valid),
        .head         (head),
        .have_credit  (have_credit),
        .pop          (ew_credit),
        .gpr_we       (gpr_we),
        .gpr_wr_idx   (gpr_wr_idx),
        .gpr_wr_data  (gpr_wr_data),
        .gpr_wr_size  (gpr_wr_size),
        .seg_we       (seg_we),
        .seg_wr_idx   (seg_wr_idx),
        .seg_wr_data  (seg_wr_data),
        .store_valid  (store_valid),
        .store_req    (store_req),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    store_credit_counter store_credit_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .spend       (store_valid),
        .refund      (store_credit),
        .have_credit (have_credit)
    );

    gpr_file gpr_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (gpr_we),
        .wr_idx  (gpr_wr_idx),
        .wr_data (gpr_wr_data),
        .wr_size (gpr_wr_size),
        .rd_idx  (gpr_rd_idx),
        .rd_data (gpr_rd_data)
    );

    seg_file seg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (seg_we),
        .wr_idx  (seg_wr_idx),
        .wr_data (seg_wr_data),
        .rd_idx  (seg_rd_idx),
        .rd_data (seg_rd_data)
    );

endmodule

//--- design/seg_file.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module seg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  arch_pkg::seg_idx_t wr_idx,
    input  arch_pkg::data_t    wr_data,
    input  arch_pkg::seg_idx_t rd_idx,
    output arch_pkg::seg_val_t rd_data
);

    import arch_pkg::*;

    seg_val_t regs [`WB_NUM_SEG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NUM_SEG; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx < `WB_NUM_SEG)) begin
            regs[wr_idx] <= wr_data[15:0];  // selector lives in low half
        end
    end

    // indexes 6 and 7 have no register behind them
    assign rd_data = (rd_idx < `WB_NUM_SEG) ? regs[rd_idx] : '0;

endmodule

//--- design/gpr_file.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module gpr_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  arch_pkg::gpr_idx_t wr_idx,
    input  arch_pkg::data_t    wr_data,
    input  arch_pkg::opsize_t  wr_size,
    input  arch_pkg::gpr_idx_t rd_idx,
    output arch_pkg::data_t    rd_data
);

    import arch_pkg::*;

    data_t regs [`WB_NUM_GPR];
    data_t merged;

    // partial writes keep the upper bits of the old value
    always_comb begin
        merged = regs[wr_idx];
        case (wr_size)
            `SIZE_BYTE: merged[7:0]  = wr_data[7:0];
            `SIZE_WORD: merged[15:0] = wr_data[15:0];
            default:    merged       = wr_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= merged;
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

//--- design/wb_sequencer.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 head_valid,
    input  pipe_pkg::ew_entry_t  head,
    input  logic                 have_credit,
    output logic                 pop,
    output logic                 gpr_we,
    output arch_pkg::gpr_idx_t   gpr_wr_idx,
    output arch_pkg::data_t      gpr_wr_data,
    output arch_pkg::opsize_t    gpr_wr_size,
    output logic                 seg_we,
    output arch_pkg::seg_idx_t   seg_wr_idx,
    output arch_pkg::data_t      seg_wr_data,
    output logic                 store_valid,
    output pipe_pkg::store_req_t store_req,
    output logic                 commit_valid,
    output pipe_pkg::commit_t    commit
);

    import arch_pkg::*;
    import pipe_pkg::*;

    localparam int slot_w = (`WB_NUM_SLOTS > 1) ? $clog2(`WB_NUM_SLOTS) : 1;

    wb_state_t                state_q;
    wb_state_t                state_d;
    logic [`WB_NUM_SLOTS-1:0] mask_q;
    logic [`WB_NUM_SLOTS-1:0] mask_d;
    logic [`WB_NUM_SLOTS-1:0] head_wb;
    logic [`WB_NUM_SLOTS-1:0] cur_mask;
    logic [`WB_NUM_SLOTS-1:0] mask_left;
    logic [slot_w-1:0]        sel_idx;
    res_slot_t                sel;
    logic                     busy;
    logic                     fast_retire;
    logic                     to_mem;
    logic                     issue;

    always_comb begin
        for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
            head_wb[i] = head.slots[i].wb;
        end
    end

    // idle works straight off the head so a waiting entry loses no cycle
    assign cur_mask = (state_q == idle) ? head_wb : mask_q;

    always_comb begin
        sel_idx = '0;
        for (int i = `WB_NUM_SLOTS - 1; i >= 0; i--) begin
            if (cur_mask[i]) begin
                sel_idx = i[slot_w-1:0];  // lowest pending slot wins
            end
        end
    end

    assign sel       = head.slots[sel_idx];
    assign mask_left = cur_mask & (cur_mask - 1'b1);  // drop lowest bit

    assign busy = head_valid && !head.ie && (cur_mask != '0) && (state_q != retire);

    // commit from idle when nothing is to be written
    assign fast_retire = (state_q == idle) && head_valid && (head.ie || cur_mask == '0);

    assign to_mem = sel.is_mem && !sel.is_reg && !sel.is_seg;
    assign issue  = busy && (!to_mem || have_credit);

    always_comb begin
        state_d = state_q;
        mask_d  = mask_q;
        if (state_q == retire) begin
            state_d = idle;
        end else if (busy) begin
            if (issue) begin
                mask_d  = mask_left;
                state_d = (mask_left == '0) ? retire : drain;
            end else begin
                mask_d  = cur_mask;  // hold the slot of a starved store
                state_d = store_wait;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
            mask_q  <= '0;
        end else begin
            state_q <= state_d;
            mask_q  <= mask_d;
        end
    end

    // reg beats seg beats mem when a slot sets more than one
    assign gpr_we      = issue && sel.is_reg;
    assign gpr_wr_idx  = sel.dest[$bits(gpr_idx_t)-1:0];
    assign gpr_wr_data = sel.value;
    assign gpr_wr_size = head.ressize;

    assign seg_we      = issue && !sel.is_reg && sel.is_seg;
    assign seg_wr_idx  = sel.dest[$bits(seg_idx_t)-1:0];
    assign seg_wr_data = sel.value;

    assign store_valid = issue && to_mem;
    assign store_req   = '{addr: sel.dest, data: sel.value, size: head.ressize};

    assign commit_valid = (state_q == retire) || fast_retire;
    assign pop          = commit_valid;  // one upstream credit per retire
    assign commit       = '{eip: head.eip, eflags: head.eflags,
                            ie: head.ie, ie_type: head.ie_type};

endmodule

//--- design/store_credit_counter.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module store_credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic spend,
    input  logic refund,
    output logic have_credit
);

    localparam int cnt_w = $clog2(`STORE_CREDITS + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= cnt_w'(`STORE_CREDITS);  // memory port starts empty
        end else begin
            case ({spend, refund})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign have_credit = (count != '0);

endmodule

//--- design/ew_latch.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module ew_latch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  pipe_pkg::ew_entry_t push_entry,
    input  logic                pop,
    output logic                head_valid,
    output pipe_pkg::ew_entry_t head
);

    import pipe_pkg::*;

    localparam int ptr_w = (`EW_DEPTH > 1) ? $clog2(`EW_DEPTH) : 1;
    localparam int cnt_w = $clog2(`EW_DEPTH + 1);

    ew_entry_t        mem [`EW_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // a push into a full queue is dropped
    assign do_push = push && (count != cnt_w'(`EW_DEPTH));
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(`EW_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(`EW_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // oldest entry goes to writeback
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

endmodule

//--- design/pipe_pkg.sv
`include "wb_params.svh"

package pipe_pkg;

    import arch_pkg::*;

    // one result of an instruction, aimed at a gpr, a segment or memory
    typedef struct packed {
        logic  wb;      // slot holds a result
        logic  is_reg;
        logic  is_seg;
        logic  is_mem;
        addr_t dest;    // low bits are the register index
        data_t value;
    } res_slot_t;

    typedef struct packed {
        addr_t                               eip;
        eflags_t                             eflags;
        logic                                ie;
        exc_type_t                           ie_type;
        opsize_t                             ressize;
        res_slot_t [`WB_NUM_SLOTS-1:0]       slots;
    } ew_entry_t;

    typedef struct packed {
        addr_t   addr;
        data_t   data;
        opsize_t size;
    } store_req_t;

    typedef struct packed {
        addr_t     eip;
        eflags_t   eflags;
        logic      ie;
        exc_type_t ie_type;
    } commit_t;

    typedef enum logic [1:0] {
        idle,
        drain,
        store_wait,
        retire
    } wb_state_t;

endpackage

//--- design/arch_pkg.sv
`include "wb_params.svh"

package arch_pkg;

    typedef logic [31:0] data_t;  // result value
    typedef logic [31:0] addr_t;  // eip or memory address

    // register indexes, sized from the file depths
    typedef logic [$clog2(`WB_NUM_GPR)-1:0] gpr_idx_t;
    typedef logic [$clog2(`WB_NUM_SEG)-1:0] seg_idx_t;

    typedef logic [15:0] seg_val_t;

    typedef logic [17:0] eflags_t;

    // byte, word or dword
    typedef logic [1:0] opsize_t;

    typedef logic [3:0] exc_type_t;

endpackage

//--- include/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// result slots carried by one instruction
`define WB_NUM_SLOTS 4

`define WB_NUM_GPR 8
`define WB_NUM_SEG 6

// queue depth and upstream credit count
`define EW_DEPTH 2

// store slots available at the memory port
`define STORE_CREDITS 2

// operand size codes
`define SIZE_BYTE  2'd0
`define SIZE_WORD  2'd1
`define SIZE_DWORD 2'd2

`endif
